// ==== sources.f ====
+incdir+.
biu_pkg.sv
biu_arbiter.sv
biu_axi_interface.sv
biu_top.sv
tb_clock_gen.sv
tb_axi_slave.sv
tb_biu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_biu_top
FILELIST  := sources.f
BUILD_DIR := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_biu_top.sv ====
`include "biu_macros.svh"

module tb_biu_top;

   import biu_pkg::*;

   localparam int NUM_TESTS       = 12;
   // per entry budget plus reset and idle cycles
   localparam int WATCHDOG_CYCLES = NUM_TESTS * 40 + 20;

   // one row of the stimulus table
   // en and err bits: [2] ifu read, [1] lsu read, [0] lsu write
   typedef struct packed {
      logic [2:0]  en;
      logic [11:0] ifu_addr;
      logic [11:0] lsu_addr;
      logic [11:0] wr_addr;
      logic [31:0] wr_data;
      logic [3:0]  wr_strb;
      logic [2:0]  err;
   } test_entry_t;

   logic               clk, arst_n;
   logic               ifu_rd_req, lsu_rd_req, lsu_wr_req;
   biu_rd_req_t        ifu_rd_cmd, lsu_rd_cmd;
   biu_wr_req_t        lsu_wr_cmd;
   logic               ifu_rd_done, lsu_rd_done, lsu_wr_done;
   logic [`BIU_DW-1:0] rd_data;
   logic               rd_err, wr_err;
   logic               ar_ready, ar_valid, r_valid, r_ready;
   logic               aw_ready, aw_valid, w_ready, w_valid;
   logic               b_valid, b_ready;
   biu_ax_t            ar_beat, aw_beat;
   biu_r_t             r_beat;
   biu_w_t             w_beat;
   biu_b_t             b_beat;

   test_entry_t        tests [NUM_TESTS];
   logic [31:0]        shadow [0:255];
   int                 errors, checks;
   // model of the read arbiter's last grant
   logic               last_gnt_ifu;

   tb_clock_gen u_clock_gen (.clk(clk), .arst_n(arst_n));

   biu_top UUT (
      .clk(clk), .arst_n(arst_n),
      .ifu_rd_req(ifu_rd_req), .ifu_rd_cmd(ifu_rd_cmd),
      .lsu_rd_req(lsu_rd_req), .lsu_rd_cmd(lsu_rd_cmd),
      .lsu_wr_req(lsu_wr_req), .lsu_wr_cmd(lsu_wr_cmd),
      .ifu_rd_done(ifu_rd_done), .lsu_rd_done(lsu_rd_done), .lsu_wr_done(lsu_wr_done),
      .rd_data(rd_data), .rd_err(rd_err), .wr_err(wr_err),
      .ar_ready(ar_ready), .ar_valid(ar_valid), .ar_beat(ar_beat),
      .r_valid(r_valid), .r_beat(r_beat), .r_ready(r_ready),
      .aw_ready(aw_ready), .aw_valid(aw_valid), .aw_beat(aw_beat),
      .w_ready(w_ready), .w_valid(w_valid), .w_beat(w_beat),
      .b_valid(b_valid), .b_beat(b_beat), .b_ready(b_ready)
   );

   tb_axi_slave u_slave (
      .clk(clk), .arst_n(arst_n),
      .ar_valid(ar_valid), .ar_beat(ar_beat), .ar_ready(ar_ready),
      .r_valid(r_valid), .r_beat(r_beat), .r_ready(r_ready),
      .aw_valid(aw_valid), .aw_beat(aw_beat), .aw_ready(aw_ready),
      .w_valid(w_valid), .w_beat(w_beat), .w_ready(w_ready),
      .b_valid(b_valid), .b_beat(b_beat), .b_ready(b_ready)
   );

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      end
   endtask

   // byte lanes with strobe set take the new data
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
      logic [31:0] result;
      result = old_word;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
      end
      return result;
   endfunction

   ////////////////////////////////////////////////////////////
   // fixed transfer attributes on accepted beats
   ////////////////////////////////////////////////////////////

   // single beat, 4 bytes, incr, no exclusive access
   always @(negedge clk) begin
      if (ar_valid && ar_ready) begin
         check_value("ar_beat.len", 32'(ar_beat.len), 32'h0);
         check_value("ar_beat.size", 32'(ar_beat.size), 32'h2);
         check_value("ar_beat.burst", 32'(ar_beat.burst), 32'h1);
         check_value("ar_beat.lock", 32'(ar_beat.lock), 32'h0);
      end
      if (aw_valid && aw_ready) begin
         check_value("aw_beat.len", 32'(aw_beat.len), 32'h0);
         check_value("aw_beat.size", 32'(aw_beat.size), 32'h2);
         check_value("aw_beat.burst", 32'(aw_beat.burst), 32'h1);
         check_value("aw_beat.lock", 32'(aw_beat.lock), 32'h0);
      end
      // the one data beat is also the last
      if (w_valid && w_ready) begin
         check_value("w_beat.last", 32'(w_beat.last), 32'h1);
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus table
   ////////////////////////////////////////////////////////////

   task automatic fill_table();
      // en      ifu      lsu rd   lsu wr   wr data         strb   err
      tests[0]  = '{3'b001, 12'h000, 12'h000, 12'h010, 32'h1122_3344, 4'hf, 3'b000};
      // first tie after reset
      tests[1]  = '{3'b110, 12'h010, 12'h020, 12'h000, 32'h0000_0000, 4'h0, 3'b000};
      tests[2]  = '{3'b001, 12'h000, 12'h000, 12'h020, 32'haabb_ccdd, 4'h5, 3'b000};
      tests[3]  = '{3'b010, 12'h000, 12'h020, 12'h000, 32'h0000_0000, 4'h0, 3'b000};
      tests[4]  = '{3'b100, 12'h100, 12'h000, 12'h000, 32'h0000_0000, 4'h0, 3'b000};
      tests[5]  = '{3'b110, 12'h104, 12'h108, 12'h000, 32'h0000_0000, 4'h0, 3'b000};
      // write and read overlap
      tests[6]  = '{3'b011, 12'h000, 12'h204, 12'h200, 32'hcafe_f00d, 4'hf, 3'b000};
      tests[7]  = '{3'b111, 12'h200, 12'h300, 12'h304, 32'h8765_4321, 4'hc, 3'b000};
      // error region, 0xf04 sits over word 0x304
      tests[8]  = '{3'b001, 12'h000, 12'h000, 12'hf04, 32'hdead_beef, 4'hf, 3'b001};
      tests[9]  = '{3'b110, 12'h304, 12'hf08, 12'h000, 32'h0000_0000, 4'h0, 3'b010};
      tests[10] = '{3'b101, 12'hf00, 12'h000, 12'h3fc, 32'h0bad_cafe, 4'hf, 3'b100};
      tests[11] = '{3'b110, 12'h000, 12'h3fc, 12'h000, 32'h0000_0000, 4'h0, 3'b000};
   endtask

   task automatic run_test(input test_entry_t t);
      logic ifu_pend, lsu_pend, wr_pend;
      logic drop_ifu, drop_lsu, drop_wr;
      logic first_seen, exp_first_ifu;
      ifu_pend      = t.en[2];
      lsu_pend      = t.en[1];
      wr_pend       = t.en[0];
      first_seen    = 1'b0;
      // tie goes to the reader not granted last
      exp_first_ifu = ~last_gnt_ifu;

      // gap cycle between entries stays quiet
      @(negedge clk);
      check_value("done pulses", 32'({ifu_rd_done, lsu_rd_done, lsu_wr_done}), 32'h0);
      check_value("rd_err/wr_err", 32'({rd_err, wr_err}), 32'h0);

      @(posedge clk);
      ifu_rd_req      <= t.en[2];
      ifu_rd_cmd.addr <= {20'h0, t.ifu_addr};
      lsu_rd_req      <= t.en[1];
      lsu_rd_cmd.addr <= {20'h0, t.lsu_addr};
      lsu_wr_req      <= t.en[0];
      lsu_wr_cmd.addr <= {20'h0, t.wr_addr};
      lsu_wr_cmd.data <= t.wr_data;
      lsu_wr_cmd.strb <= t.wr_strb;

      while (ifu_pend || lsu_pend || wr_pend) begin
         drop_ifu = 1'b0;
         drop_lsu = 1'b0;
         drop_wr  = 1'b0;
         @(negedge clk);
         if (ifu_rd_done) begin
            // a done for an idle requester shows up as a mismatch
            check_value("ifu_rd_done", 32'(ifu_rd_done), 32'(ifu_pend));
            check_value("rd_err (ifu)", 32'(rd_err), 32'(t.err[2]));
            if (!t.err[2]) check_value("rd_data (ifu)", rd_data, shadow[t.ifu_addr[9:2]]);
            if (t.en[2] && t.en[1] && !first_seen) begin
               check_value("first read owner is ifu", 32'h1, 32'(exp_first_ifu));
            end
            first_seen = 1'b1;
            ifu_pend   = 1'b0;
            drop_ifu   = 1'b1;
         end
         if (lsu_rd_done) begin
            check_value("lsu_rd_done", 32'(lsu_rd_done), 32'(lsu_pend));
            check_value("rd_err (lsu)", 32'(rd_err), 32'(t.err[1]));
            if (!t.err[1]) check_value("rd_data (lsu)", rd_data, shadow[t.lsu_addr[9:2]]);
            if (t.en[2] && t.en[1] && !first_seen) begin
               check_value("first read owner is ifu", 32'h0, 32'(exp_first_ifu));
            end
            first_seen = 1'b1;
            lsu_pend   = 1'b0;
            drop_lsu   = 1'b1;
         end
         if (lsu_wr_done) begin
            check_value("lsu_wr_done", 32'(lsu_wr_done), 32'(wr_pend));
            check_value("wr_err", 32'(wr_err), 32'(t.err[0]));
            if (!t.err[0]) begin
               shadow[t.wr_addr[9:2]] = merge_bytes(shadow[t.wr_addr[9:2]],
                                                    t.wr_data, t.wr_strb);
            end
            wr_pend = 1'b0;
            drop_wr = 1'b1;
         end
         // req falls in the cycle after done
         @(posedge clk);
         if (drop_ifu) ifu_rd_req <= 1'b0;
         if (drop_lsu) lsu_rd_req <= 1'b0;
         if (drop_wr)  lsu_wr_req <= 1'b0;
      end

      // the later grant of a tie becomes the last one
      if (t.en[2] && t.en[1]) last_gnt_ifu = ~exp_first_ifu;
      else if (t.en[2])       last_gnt_ifu = 1'b1;
      else if (t.en[1])       last_gnt_ifu = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      ifu_rd_req   <= 1'b0;
      ifu_rd_cmd   <= '0;
      lsu_rd_req   <= 1'b0;
      lsu_rd_cmd   <= '0;
      lsu_wr_req   <= 1'b0;
      lsu_wr_cmd   <= '0;
      errors       = 0;
      checks       = 0;
      last_gnt_ifu = 1'b0;
      fill_table();

      @(posedge arst_n);
      // shadow starts from the slave's fill pattern
      for (int i = 0; i < 256; i++) begin
         shadow[i[7:0]] = u_slave.mem[i[7:0]];
      end

      // quiet bus before the first request
      repeat (3) begin
         @(negedge clk);
         check_value("done pulses", 32'({ifu_rd_done, lsu_rd_done, lsu_wr_done}), 32'h0);
         check_value("rd_err/wr_err", 32'({rd_err, wr_err}), 32'h0);
         check_value("ar/aw/w valid", 32'({ar_valid, aw_valid, w_valid}), 32'h0);
      end

      for (int i = 0; i < NUM_TESTS; i++) begin
         run_test(tests[i]);
      end

      @(negedge clk);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("ERROR: timeout, a request never completed");
      $display("Test failed");
      $finish;
   end

endmodule

// ==== tb_axi_slave.sv ====
`include "biu_macros.svh"

module tb_axi_slave (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             ar_valid,
   input  biu_pkg::biu_ax_t ar_beat,
   output logic             ar_ready,
   output logic             r_valid,
   output biu_pkg::biu_r_t  r_beat,
   input  logic             r_ready,
   input  logic             aw_valid,
   input  biu_pkg::biu_ax_t aw_beat,
   output logic             aw_ready,
   input  logic             w_valid,
   input  biu_pkg::biu_w_t  w_beat,
   output logic             w_ready,
   output logic             b_valid,
   output biu_pkg::biu_b_t  b_beat,
   input  logic             b_ready
);

   import biu_pkg::*;

   // everything from here up answers slverr
   localparam logic [31:0] ERR_BASE = 32'h0000_0f00;

   logic [31:0] mem [0:255];
   integer      seed = 32'hc1de_d1a7;
   logic [31:0] rnd;
   logic [31:0] merged;
   // remaining wait cycles per channel
   logic [1:0]  ar_wait, r_wait, aw_wait, w_wait, b_wait;
   logic        r_pend, aw_got, w_got;
   biu_ax_t     ar_q, aw_q;
   biu_w_t      w_q;

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ar_ready <= 1'b0;
         r_valid  <= 1'b0;
         r_beat   <= '0;
         aw_ready <= 1'b0;
         w_ready  <= 1'b0;
         b_valid  <= 1'b0;
         b_beat   <= '0;
         r_pend   <= 1'b0;
         aw_got   <= 1'b0;
         w_got    <= 1'b0;
         rnd = $random(seed);
         ar_wait  <= rnd[1:0];
         aw_wait  <= rnd[3:2];
         w_wait   <= rnd[5:4];
         r_wait   <= 2'd0;
         b_wait   <= 2'd0;
         // fill word built from its byte address
         for (int i = 0; i < 256; i++) begin
            mem[i[7:0]] <= {~(16'(i) << 2), (16'(i) << 2)};
         end
      end else begin
         ////////////////////////////////////////////////////////////
         // read address and data
         ////////////////////////////////////////////////////////////
         if (ar_valid && ar_ready) begin
            ar_ready <= 1'b0;
            ar_q     <= ar_beat;
            r_pend   <= 1'b1;
            rnd = $random(seed);
            r_wait   <= rnd[1:0];
            ar_wait  <= rnd[3:2];
         end else if (ar_valid) begin
            if (ar_wait == 2'd0) ar_ready <= 1'b1;
            else ar_wait <= ar_wait - 2'd1;
         end

         if (r_valid && r_ready) begin
            r_valid <= 1'b0;
         end else if (r_pend && !r_valid) begin
            if (r_wait == 2'd0) begin
               r_valid     <= 1'b1;
               r_pend      <= 1'b0;
               r_beat.id   <= ar_q.id;
               r_beat.last <= 1'b1;
               if (ar_q.addr >= ERR_BASE) begin
                  r_beat.data <= '0;
                  r_beat.resp <= SLVERR;
               end else begin
                  r_beat.data <= mem[ar_q.addr[9:2]];
                  r_beat.resp <= OKAY;
               end
            end else begin
               r_wait <= r_wait - 2'd1;
            end
         end

         ////////////////////////////////////////////////////////////
         // write address, data and response
         ////////////////////////////////////////////////////////////
         if (aw_valid && aw_ready) begin
            aw_ready <= 1'b0;
            aw_q     <= aw_beat;
            aw_got   <= 1'b1;
            rnd = $random(seed);
            aw_wait  <= rnd[1:0];
            b_wait   <= rnd[3:2];
         end else if (aw_valid) begin
            if (aw_wait == 2'd0) aw_ready <= 1'b1;
            else aw_wait <= aw_wait - 2'd1;
         end

         if (w_valid && w_ready) begin
            w_ready <= 1'b0;
            w_q     <= w_beat;
            w_got   <= 1'b1;
            rnd = $random(seed);
            w_wait  <= rnd[1:0];
         end else if (w_valid) begin
            if (w_wait == 2'd0) w_ready <= 1'b1;
            else w_wait <= w_wait - 2'd1;
         end

         // response once both halves of the write are in
         if (b_valid && b_ready) begin
            b_valid <= 1'b0;
         end else if (aw_got && w_got && !b_valid) begin
            if (b_wait == 2'd0) begin
               b_valid   <= 1'b1;
               b_beat.id <= aw_q.id;
               aw_got    <= 1'b0;
               w_got     <= 1'b0;
               if (aw_q.addr >= ERR_BASE) begin
                  // error region keeps memory as it is
                  b_beat.resp <= SLVERR;
               end else begin
                  b_beat.resp <= OKAY;
                  merged = mem[aw_q.addr[9:2]];
                  for (int b = 0; b < 4; b++) begin
                     if (w_q.strb[b]) merged[8*b +: 8] = w_q.data[8*b +: 8];
                  end
                  mem[aw_q.addr[9:2]] <= merged;
               end
            end else begin
               b_wait <= b_wait - 2'd1;
            end
         end
      end
   end

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
   parameter int PERIOD       = 100,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic arst_n
);

   // free running clock
   initial begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   // reset low from time 0, released on a rising edge
   initial begin
      arst_n <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
   end

endmodule

// ==== biu_top.sv ====
`include "biu_macros.svh"

module biu_top (
   input  logic                 clk,
   input  logic                 arst_n,

   // requester side
   input  logic                 ifu_rd_req,
   input  biu_pkg::biu_rd_req_t ifu_rd_cmd,
   input  logic                 lsu_rd_req,
   input  biu_pkg::biu_rd_req_t lsu_rd_cmd,
   input  logic                 lsu_wr_req,
   input  biu_pkg::biu_wr_req_t lsu_wr_cmd,
   output logic                 ifu_rd_done,
   output logic                 lsu_rd_done,
   output logic                 lsu_wr_done,
   output logic [`BIU_DW-1:0]   rd_data,
   output logic                 rd_err,
   output logic                 wr_err,

   // axi master
   input  logic                 ar_ready,
   output logic                 ar_valid,
   output biu_pkg::biu_ax_t     ar_beat,
   input  logic                 r_valid,
   input  biu_pkg::biu_r_t      r_beat,
   output logic                 r_ready,
   input  logic                 aw_ready,
   output logic                 aw_valid,
   output biu_pkg::biu_ax_t     aw_beat,
   input  logic                 w_ready,
   output logic                 w_valid,
   output biu_pkg::biu_w_t      w_beat,
   input  logic                 b_valid,
   input  biu_pkg::biu_b_t      b_beat,
   output logic                 b_ready
);

   import biu_pkg::*;

   // arbiter to interface
   logic    arb_rd_val;
   biu_ax_t arb_rd_cmd;
   logic    arb_wr_val;
   biu_ax_t arb_wr_cmd;
   biu_w_t  arb_wr_data;

   // interface back to arbiter
   logic    rd_fin;
   logic    wr_fin;

   biu_arbiter u_arbiter (
      .clk         (clk),
      .arst_n      (arst_n),
      .ifu_rd_req  (ifu_rd_req),
      .ifu_rd_cmd  (ifu_rd_cmd),
      .lsu_rd_req  (lsu_rd_req),
      .lsu_rd_cmd  (lsu_rd_cmd),
      .lsu_wr_req  (lsu_wr_req),
      .lsu_wr_cmd  (lsu_wr_cmd),
      .rd_fin      (rd_fin),
      .wr_fin      (wr_fin),
      .arb_rd_val  (arb_rd_val),
      .arb_rd_cmd  (arb_rd_cmd),
      .arb_wr_val  (arb_wr_val),
      .arb_wr_cmd  (arb_wr_cmd),
      .arb_wr_data (arb_wr_data)
   );

   biu_axi_interface u_axi_interface (
      .clk         (clk),
      .arst_n      (arst_n),
      .arb_rd_val  (arb_rd_val),
      .arb_rd_cmd  (arb_rd_cmd),
      .arb_wr_val  (arb_wr_val),
      .arb_wr_cmd  (arb_wr_cmd),
      .arb_wr_data (arb_wr_data),
      .ar_ready    (ar_ready),
      .ar_valid    (ar_valid),
      .ar_beat     (ar_beat),
      .r_valid     (r_valid),
      .r_beat      (r_beat),
      .r_ready     (r_ready),
      .aw_ready    (aw_ready),
      .aw_valid    (aw_valid),
      .aw_beat     (aw_beat),
      .w_ready     (w_ready),
      .w_valid     (w_valid),
      .w_beat      (w_beat),
      .b_valid     (b_valid),
      .b_beat      (b_beat),
      .b_ready     (b_ready),
      .rd_fin      (rd_fin),
      .wr_fin      (wr_fin),
      .rd_data     (rd_data),
      .ifu_rd_done (ifu_rd_done),
      .lsu_rd_done (lsu_rd_done),
      .lsu_wr_done (lsu_wr_done),
      .rd_err      (rd_err),
      .wr_err      (wr_err)
   );

endmodule

// ==== biu_axi_interface.sv ====
`include "biu_macros.svh"

module biu_axi_interface (
   input  logic               clk,
   input  logic               arst_n,

   // arbitrated read
   input  logic               arb_rd_val,
   input  biu_pkg::biu_ax_t   arb_rd_cmd,

   // arbitrated write
   input  logic               arb_wr_val,
   input  biu_pkg::biu_ax_t   arb_wr_cmd,
   input  biu_pkg::biu_w_t    arb_wr_data,

   // axi read address
   input  logic               ar_ready,
   output logic               ar_valid,
   output biu_pkg::biu_ax_t   ar_beat,

   // axi read data
   input  logic               r_valid,
   input  biu_pkg::biu_r_t    r_beat,
   output logic               r_ready,

   // axi write address
   input  logic               aw_ready,
   output logic               aw_valid,
   output biu_pkg::biu_ax_t   aw_beat,

   // axi write data
   input  logic               w_ready,
   output logic               w_valid,
   output biu_pkg::biu_w_t    w_beat,

   // axi write response
   input  logic               b_valid,
   input  biu_pkg::biu_b_t    b_beat,
   output logic               b_ready,

   // completions
   output logic               rd_fin,
   output logic               wr_fin,
   output logic [`BIU_DW-1:0] rd_data,
   output logic               ifu_rd_done,
   output logic               lsu_rd_done,
   output logic               lsu_wr_done,
   output logic               rd_err,
   output logic               wr_err
);

   import biu_pkg::*;

   // held command payload
   biu_ax_t ar_cmd_q;
   biu_ax_t aw_cmd_q;
   biu_w_t  w_data_q;

   // channel valids
   logic    ar_valid_q;
   logic    aw_valid_q;
   logic    w_valid_q;

   ////////////////////////////////////////////////////////////
   // ar channel
   ////////////////////////////////////////////////////////////

   // val pulse loads the command, valid follows one cycle later
   //
   //   arb_rd_val  _-______
   //   ar_ready    ____-___
   //   ar_valid    __---___
   //
   // the arbiter holds off the next val until rd_fin
   // so the held command is never overwritten

   always_ff @(posedge clk) begin
      if (arb_rd_val) begin
         ar_cmd_q <= arb_rd_cmd;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ar_valid_q <= 1'b0;
      end else begin
         // hold until ready is sampled high
         ar_valid_q <= arb_rd_val | (ar_valid_q & ~ar_ready);
      end
   end

   assign ar_valid = ar_valid_q;
   assign ar_beat  = ar_cmd_q;

   ////////////////////////////////////////////////////////////
   // r channel
   ////////////////////////////////////////////////////////////

   // always accept read data
   assign r_ready = 1'b1;

   // single beat, last marks the end anyway
   assign rd_fin  = r_valid & r_ready & r_beat.last;
   // data straight from the bus, no capture register
   assign rd_data = r_beat.data;

   // route the completion by id
   assign ifu_rd_done = rd_fin & (r_beat.id == ID_IFU);
   assign lsu_rd_done = rd_fin & (r_beat.id == ID_LSU_RD);
   // slverr or decerr
   assign rd_err      = rd_fin & (r_beat.resp != OKAY);

   ////////////////////////////////////////////////////////////
   // aw and w channels
   ////////////////////////////////////////////////////////////

   // one val pulse loads both, then aw and w run independently
   always_ff @(posedge clk) begin
      if (arb_wr_val) begin
         aw_cmd_q <= arb_wr_cmd;
         w_data_q <= arb_wr_data;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         aw_valid_q <= 1'b0;
         w_valid_q  <= 1'b0;
      end else begin
         // each drops on its own ready
         aw_valid_q <= arb_wr_val | (aw_valid_q & ~aw_ready);
         w_valid_q  <= arb_wr_val | (w_valid_q & ~w_ready);
      end
   end

   assign aw_valid = aw_valid_q;
   assign aw_beat  = aw_cmd_q;
   assign w_valid  = w_valid_q;
   assign w_beat   = w_data_q;

   ////////////////////////////////////////////////////////////
   // b channel
   ////////////////////////////////////////////////////////////

   assign b_ready = 1'b1;

   // write is done only when the response is back
   assign wr_fin      = b_valid & b_ready;
   assign lsu_wr_done = wr_fin & (b_beat.id == ID_LSU_WR);
   assign wr_err      = wr_fin & (b_beat.resp != OKAY);

endmodule

// ==== biu_arbiter.sv ====
`include "biu_macros.svh"

module biu_arbiter (
   input  logic                 clk,
   input  logic                 arst_n,

   // instruction fetch read
   input  logic                 ifu_rd_req,
   input  biu_pkg::biu_rd_req_t ifu_rd_cmd,

   // load/store read and write
   input  logic                 lsu_rd_req,
   input  biu_pkg::biu_rd_req_t lsu_rd_cmd,
   input  logic                 lsu_wr_req,
   input  biu_pkg::biu_wr_req_t lsu_wr_cmd,

   // completions from the axi interface
   input  logic                 rd_fin,
   input  logic                 wr_fin,

   // arbitrated commands
   output logic                 arb_rd_val,
   output biu_pkg::biu_ax_t     arb_rd_cmd,
   output logic                 arb_wr_val,
   output biu_pkg::biu_ax_t     arb_wr_cmd,
   output biu_pkg::biu_w_t      arb_wr_data
);

   import biu_pkg::*;

   biu_arb_state_e rd_state_q;
   biu_arb_state_e rd_state_d;
   // 1 when the last read grant went to the ifu
   logic           last_gnt_ifu_q;
   logic           rd_gnt_ifu;
   // one write in flight at most
   logic           wr_busy_q;

   // address beat with the fixed single beat attributes
   function automatic biu_ax_t make_ax(input biu_id_e            id,
                                       input logic [`BIU_AW-1:0] addr);
      biu_ax_t ax;
      ax.id    = id;
      ax.addr  = addr;
      ax.len   = `BIU_LEN;
      ax.size  = `BIU_SIZE;
      ax.burst = `BIU_BURST;
      ax.lock  = 1'b0;
      ax.cache = `BIU_CACHE;
      ax.prot  = `BIU_PROT;
      return ax;
   endfunction

   ////////////////////////////////////////////////////////////
   // read side
   ////////////////////////////////////////////////////////////

   // ifu wins when alone, or on a tie when lsu had the last grant
   // reset value makes ifu win the first tie
   assign rd_gnt_ifu = ifu_rd_req & (~lsu_rd_req | ~last_gnt_ifu_q);

   // issue in the same cycle req is seen while idle
   assign arb_rd_val = (rd_state_q == RD_IDLE) & (ifu_rd_req | lsu_rd_req);
   assign arb_rd_cmd = rd_gnt_ifu ? make_ax(ID_IFU, ifu_rd_cmd.addr)
                                  : make_ax(ID_LSU_RD, lsu_rd_cmd.addr);

   always_comb begin
      rd_state_d = rd_state_q;
      case (rd_state_q)
         RD_IDLE: begin
            // held req must not pulse again
            if (arb_rd_val) begin
               rd_state_d = RD_BUSY;
            end
         end
         RD_BUSY: begin
            if (rd_fin) begin
               rd_state_d = RD_IDLE;
            end
         end
         default: begin
            rd_state_d = RD_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_state_q     <= RD_IDLE;
         last_gnt_ifu_q <= 1'b0;
      end else begin
         rd_state_q <= rd_state_d;
         // remember winner for alternation
         if (arb_rd_val) begin
            last_gnt_ifu_q <= rd_gnt_ifu;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // write side
   ////////////////////////////////////////////////////////////

   // lsu is the only writer
   assign arb_wr_val = lsu_wr_req & ~wr_busy_q;
   assign arb_wr_cmd = make_ax(ID_LSU_WR, lsu_wr_cmd.addr);

   always_comb begin
      arb_wr_data.data = lsu_wr_cmd.data;
      arb_wr_data.strb = lsu_wr_cmd.strb;
      // single beat, always last
      arb_wr_data.last = 1'b1;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_busy_q <= 1'b0;
      end else if (arb_wr_val) begin
         wr_busy_q <= 1'b1;
      end else if (wr_fin) begin
         // b beat returned
         wr_busy_q <= 1'b0;
      end
   end

endmodule

// ==== biu_pkg.sv ====
`include "biu_macros.svh"

package biu_pkg;

   // owner of a transaction, sent on ar/aw id and echoed on r/b id
   typedef enum logic [`BIU_IDW-1:0] {
      ID_IFU    = 4'd0,
      ID_LSU_RD = 4'd1,
      ID_LSU_WR = 4'd2
   } biu_id_e;

   // axi response codes
   typedef enum logic [`BIU_RESPW-1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } biu_resp_e;

   // read side of the arbiter
   typedef enum logic {
      RD_IDLE = 1'b0,
      RD_BUSY = 1'b1
   } biu_arb_state_e;

   ////////////////////////////////////////////////////////////
   // requester commands
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [`BIU_AW-1:0] addr;
   } biu_rd_req_t;

   typedef struct packed {
      logic [`BIU_AW-1:0] addr;
      logic [`BIU_DW-1:0] data;
      logic [`BIU_SW-1:0] strb;
   } biu_wr_req_t;

   ////////////////////////////////////////////////////////////
   // axi channel beats
   ////////////////////////////////////////////////////////////

   // ar and aw, 57 bits
   typedef struct packed {
      logic [`BIU_IDW-1:0]    id;
      logic [`BIU_AW-1:0]     addr;
      logic [`BIU_LENW-1:0]   len;
      logic [`BIU_SIZEW-1:0]  size;
      logic [`BIU_BURSTW-1:0] burst;
      logic                   lock;
      logic [`BIU_CACHEW-1:0] cache;
      logic [`BIU_PROTW-1:0]  prot;
   } biu_ax_t;

   typedef struct packed {
      logic [`BIU_DW-1:0] data;
      logic [`BIU_SW-1:0] strb;
      logic               last;
   } biu_w_t;

   typedef struct packed {
      logic [`BIU_IDW-1:0] id;
      logic [`BIU_DW-1:0]  data;
      biu_resp_e           resp;
      logic                last;
   } biu_r_t;

   typedef struct packed {
      logic [`BIU_IDW-1:0] id;
      biu_resp_e           resp;
   } biu_b_t;

endpackage

// ==== biu_macros.svh ====
`ifndef BIU_MACROS_SVH
`define BIU_MACROS_SVH

// bus widths
`define BIU_AW      32
`define BIU_DW      32
// one strobe bit per data byte
`define BIU_SW      (`BIU_DW/8)
// axi id width
`define BIU_IDW     4

// axi field widths
`define BIU_LENW    8
`define BIU_SIZEW   3
`define BIU_BURSTW  2
`define BIU_CACHEW  4
`define BIU_PROTW   3
`define BIU_RESPW   2

// fixed single beat attributes
`define BIU_LEN     8'd0
// 4 bytes per beat
`define BIU_SIZE    3'd2
// incr
`define BIU_BURST   2'b01
// normal non-cacheable bufferable
`define BIU_CACHE   4'b0011
// unprivileged secure data access
`define BIU_PROT    3'b000

`endif
